/* sim.f */
hdl/na_pkg.sv
hdl/na_flit_fifo.sv
hdl/na_wb_decode.sv
hdl/na_conf.sv
hdl/na_mp_channel.sv
hdl/na_top.sv
dv/na_fifo_props.sv
dv/na_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the adapter testbench with Verilator and runs it; exit status 0 only on pass

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f sim.f --top-module na_tb -Mdir "$BUILD_DIR" -o na_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/na_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
   echo "Result: pass"
   exit 0
else
   echo "Result: fail, see $LOG"
   exit 1
fi

/* dv/na_tb.sv */
// Random test of the adapter over Wishbone and both NoC channels; needs a simulator with timing
module na_tb
   import na_pkg::*;
();

   localparam int unsigned SEED       = 32'h33aa_38ab;
   localparam int          MAX_FLITS  = 4;
   localparam int          N_SEND_PKT = 40;
   localparam int          ROUNDS     = 8;
   localparam int          PKT_ROUND  = 3;   // Per channel, at most 12 flits fit the receive queue
   localparam int          N_RECV_PKT = ROUNDS * PKT_ROUND * CHANNELS;
   // Up to 50 cycles per flit with out-ready stalls, plus reset, config and error accesses
   localparam int          CYCLE_LIMIT = (N_SEND_PKT + N_RECV_PKT) * MAX_FLITS * 50 + 2400;

   logic                                clk;
   logic                                rst_n;
   logic [ADDR_WIDTH-1:0]               wb_adr;
   logic [BUS_WIDTH-1:0]                wb_dat_w;
   logic [SEL_WIDTH-1:0]                wb_sel;
   logic                                wb_we;
   logic                                wb_cyc;
   logic                                wb_stb;
   logic [BUS_WIDTH-1:0]                wb_dat_r;
   logic                                wb_ack;
   logic                                wb_err;
   logic [CHANNELS-1:0][FLIT_WIDTH-1:0] noc_in_flit;
   logic [CHANNELS-1:0]                 noc_in_last;
   logic [CHANNELS-1:0]                 noc_in_valid;
   logic [CHANNELS-1:0]                 noc_in_ready;
   logic [CHANNELS-1:0][FLIT_WIDTH-1:0] noc_out_flit;
   logic [CHANNELS-1:0]                 noc_out_last;
   logic [CHANNELS-1:0]                 noc_out_valid;
   logic [CHANNELS-1:0]                 noc_out_ready;
   logic                                irq;

   logic [32:0]         inj_q [CHANNELS][$];     // {last, flit} waiting to enter the NoC port
   logic [32:0]         exp_out [CHANNELS][$];   // Flits expected on noc_out
   logic [32:0]         exp_recv [CHANNELS][$];  // Model of the receive queues
   logic [CHANNELS-1:0] in_xfer;
   logic                irq_en_model;
   logic                last_irq;
   int                  mism_cnt;
   int                  other_cnt;
   int                  cycles;

   na_top u_dut (
      .clk             (clk),
      .rst_n_i         (rst_n),
      .wb_adr_i        (wb_adr),
      .wb_dat_i        (wb_dat_w),
      .wb_sel_i        (wb_sel),
      .wb_we_i         (wb_we),
      .wb_cyc_i        (wb_cyc),
      .wb_stb_i        (wb_stb),
      .wb_dat_o        (wb_dat_r),
      .wb_ack_o        (wb_ack),
      .wb_err_o        (wb_err),
      .noc_in_flit_i   (noc_in_flit),
      .noc_in_last_i   (noc_in_last),
      .noc_in_valid_i  (noc_in_valid),
      .noc_in_ready_o  (noc_in_ready),
      .noc_out_flit_o  (noc_out_flit),
      .noc_out_last_o  (noc_out_last),
      .noc_out_valid_o (noc_out_valid),
      .noc_out_ready_i (noc_out_ready),
      .irq_o           (irq)
   );

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles == CYCLE_LIMIT) begin
         $display("TIMEOUT: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   function automatic logic [31:0] mp_addr(input int c, input logic [7:0] ofs);
      return (32'(WIN_MP) << WIN_LSB) | (32'(c) << CHAN_BIT) | 32'(ofs);
   endfunction

   function automatic logic [31:0] conf_addr(input logic [7:0] ofs);
      return (32'(WIN_CONF) << WIN_LSB) | 32'(ofs);
   endfunction

   // Bit 0 receive not empty, bit 1 next flit is last, bit 2 send space
   function automatic logic [31:0] status_word(input logic ne, input logic lst, input logic spc);
      return {29'b0, spc, lst, ne};
   endfunction

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("MISMATCH %s: expected 0x%08h, actual 0x%08h", name, exp, act);
         mism_cnt++;
      end
   endtask

   task automatic check_irq(input string name);
      logic exp;
      exp = irq_en_model & ((exp_recv[0].size() != 0) | (exp_recv[1].size() != 0));
      check(name, 32'(exp), 32'(last_irq));
   endtask

   // One single Wishbone transfer, outputs sampled on the falling edge
   task automatic bus_xfer(input logic [31:0] adr, input logic we, input logic [31:0] wdat,
                           output logic [31:0] rdat, output logic ack, output logic err);
      @(posedge clk);
      wb_adr   <= adr;
      wb_we    <= we;
      wb_dat_w <= wdat;
      wb_sel   <= 4'hF;
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      do @(negedge clk); while (!(wb_ack || wb_err));
      ack      = wb_ack;
      err      = wb_err;
      rdat     = wb_dat_r;
      last_irq = irq;
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic bus_read(input logic [31:0] adr, input string name, input logic [31:0] exp);
      logic [31:0] rd;
      logic        ack;
      logic        err;
      bus_xfer(adr, 1'b0, '0, rd, ack, err);
      check({name, " ack"}, 32'd1, 32'(ack));
      check({name, " err"}, 32'd0, 32'(err));
      check(name, exp, rd);
      check_irq({name, " irq"});
   endtask

   task automatic bus_write(input logic [31:0] adr, input logic [31:0] dat, input string name);
      logic [31:0] rd;
      logic        ack;
      logic        err;
      bus_xfer(adr, 1'b1, dat, rd, ack, err);
      check({name, " ack"}, 32'd1, 32'(ack));
      check({name, " err"}, 32'd0, 32'(err));
      check_irq({name, " irq"});
   endtask

   task automatic send_packet(input int c);
      int          len;
      logic [31:0] d;
      len = 1 + int'($urandom % MAX_FLITS);
      for (int i = 0; i < len; i++) begin
         d = $urandom;
         exp_out[c].push_back({i == len - 1, d});
         bus_write(mp_addr(c, (i == len - 1) ? REG_SEND_LAST : REG_SEND), d, "send");
      end
   endtask

   // Half the packets are MP class, the rest any random class
   task automatic inject_round();
      int          len;
      logic [2:0]  cls;
      logic [31:0] f;
      for (int c = 0; c < CHANNELS; c++) begin
         for (int p = 0; p < PKT_ROUND; p++) begin
            len = 1 + int'($urandom % MAX_FLITS);
            cls = ($urandom % 2 == 0) ? CLASS_MP : 3'($urandom);
            for (int i = 0; i < len; i++) begin
               f = $urandom;
               if (i == 0) f[26:24] = cls;   // Header class field
               inj_q[c].push_back({i == len - 1, f});
               if (cls == CLASS_MP) exp_recv[c].push_back({i == len - 1, f});
            end
         end
      end
   endtask

   task automatic drain_channel(input int c);
      logic [32:0] e;
      while (exp_recv[c].size() != 0) begin
         bus_read(mp_addr(c, REG_STATUS), $sformatf("recv%0d status", c),
                  status_word(1'b1, exp_recv[c][0][32], 1'b1));
         e = exp_recv[c].pop_front();
         bus_read(mp_addr(c, REG_RECV), $sformatf("recv%0d flit", c), e[31:0]);
      end
      bus_read(mp_addr(c, REG_STATUS), $sformatf("recv%0d empty", c), status_word(0, 0, 1));
   endtask

   // NoC sinks, ready mostly low so the send path backs up
   always @(posedge clk) begin
      for (int c = 0; c < CHANNELS; c++) noc_out_ready[c] <= ($urandom % 5 == 0);
   end

   // NoC sources
   always @(posedge clk) begin
      for (int c = 0; c < CHANNELS; c++) begin
         if (!noc_in_valid[c] || in_xfer[c]) begin
            if (inj_q[c].size() != 0 && ($urandom % 4 != 0)) begin
               {noc_in_last[c], noc_in_flit[c]} <= inj_q[c].pop_front();
               noc_in_valid[c] <= 1'b1;
            end else begin
               noc_in_valid[c] <= 1'b0;
            end
         end
      end
   end

   // Handshakes seen here complete on the next rising edge
   always @(negedge clk) begin
      logic [32:0] e;
      for (int c = 0; c < CHANNELS; c++) begin
         in_xfer[c] = noc_in_valid[c] & noc_in_ready[c];
         if (rst_n && noc_out_valid[c] && noc_out_ready[c]) begin
            if (exp_out[c].size() == 0) begin
               $display("ERROR: flit on noc_out channel %0d that was never sent", c);
               other_cnt++;
            end else begin
               e = exp_out[c].pop_front();
               check($sformatf("noc_out%0d flit", c), e[31:0], noc_out_flit[c]);
               check($sformatf("noc_out%0d last", c), 32'(e[32]), 32'(noc_out_last[c]));
            end
         end
      end
   end

   initial begin
      logic [31:0] adr;
      logic [31:0] rd;
      logic        ack;
      logic        err;
      void'($urandom(SEED));
      clk = 1'b0;
      rst_n = 1'b0;
      wb_adr = '0;
      wb_dat_w = '0;
      wb_sel = '0;
      wb_we = 1'b0;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      noc_in_flit = '0;
      noc_in_last = '0;
      noc_in_valid = '0;
      noc_out_ready = '0;
      in_xfer = '0;
      irq_en_model = 1'b0;
      last_irq = 1'b0;
      mism_cnt = 0;
      other_cnt = 0;
      cycles = 0;
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;

      bus_read(conf_addr(REG_TILE_ID), "tile id", TILE_ID);
      bus_read(conf_addr(REG_CHANNELS), "channels", CHANNELS);
      bus_write(conf_addr(REG_TILE_ID), 32'hFF, "tile id write");
      bus_read(conf_addr(REG_TILE_ID), "tile id read-only", TILE_ID);
      bus_read(conf_addr(REG_IRQ_EN), "irq en reset", 32'd0);
      irq_en_model = 1'b1;
      bus_write(conf_addr(REG_IRQ_EN), 32'd1, "irq en write");
      bus_read(conf_addr(REG_IRQ_EN), "irq en readback", 32'd1);

      for (int w = 2; w < 16; w++) begin
         adr = (32'(w) << WIN_LSB) | ($urandom & 32'h1FC);
         bus_xfer(adr, 1'($urandom), $urandom, rd, ack, err);
         check("unmapped err", 32'd1, 32'(err));
         check("unmapped ack", 32'd0, 32'(ack));
         check_irq("unmapped irq");
      end

      for (int n = 0; n < N_SEND_PKT; n++) send_packet(int'($urandom % CHANNELS));
      while (exp_out[0].size() != 0 || exp_out[1].size() != 0) @(negedge clk);

      for (int r = 0; r < ROUNDS; r++) begin
         inject_round();
         while (inj_q[0].size() != 0 || inj_q[1].size() != 0 || noc_in_valid != '0)
            @(negedge clk);
         repeat (2) @(negedge clk);   // Input buffer to receive queue
         // Odd rounds drain with the interrupt masked
         irq_en_model = (r % 2 == 0);
         bus_write(conf_addr(REG_IRQ_EN), 32'(irq_en_model), "irq en round");
         for (int c = 0; c < CHANNELS; c++) drain_channel(c);
      end

      $display("Check summary: %0d mismatches, %0d other errors", mism_cnt, other_cnt);
      if (mism_cnt == 0 && other_cnt == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

/* dv/na_fifo_props.sv */
// Output handshake and occupancy checks bound to every na_flit_fifo; input side is not checked
module na_fifo_props
   import na_pkg::*;
#(
   parameter int DEPTH = 4
) (
   input logic                       clk,
   input logic                       rst_n_i,
   input logic [FLIT_WIDTH-1:0]      out_flit_i,
   input logic                       out_last_i,
   input logic                       out_valid_i,
   input logic                       out_ready_i,
   input logic [$clog2(DEPTH+1)-1:0] count_i
);

   a_valid_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
      out_valid_i && !out_ready_i |=> out_valid_i)
      else $error("FIFO out_valid dropped before out_ready");

   // Head flit frozen while stalled
   a_flit_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
      out_valid_i && !out_ready_i |=> $stable(out_flit_i) && $stable(out_last_i))
      else $error("FIFO head flit changed while stalled");

   a_count_max: assert property (@(posedge clk) disable iff (!rst_n_i)
      count_i <= DEPTH)
      else $error("FIFO count above depth");

   a_reset_idle: assert property (@(posedge clk) !rst_n_i |-> !out_valid_i)
      else $error("FIFO out_valid high during reset");

endmodule

bind na_flit_fifo na_fifo_props #(.DEPTH(DEPTH)) u_props (
   .clk         (clk),
   .rst_n_i     (rst_n_i),
   .out_flit_i  (out_flit_o),
   .out_last_i  (out_last_o),
   .out_valid_i (out_valid_o),
   .out_ready_i (out_ready_i),
   .count_i     (count_o)
);

/* hdl/na_top.sv */
// Network adapter top, message passing only; channel 0 requests, channel 1 responses
module na_top
   import na_pkg::*;
(
   input  logic                                clk,
   input  logic                                rst_n_i,
   input  logic [ADDR_WIDTH-1:0]               wb_adr_i,
   input  logic [BUS_WIDTH-1:0]                wb_dat_i,
   input  logic [SEL_WIDTH-1:0]                wb_sel_i,
   input  logic                                wb_we_i,
   input  logic                                wb_cyc_i,
   input  logic                                wb_stb_i,
   output logic [BUS_WIDTH-1:0]                wb_dat_o,
   output logic                                wb_ack_o,
   output logic                                wb_err_o,
   input  logic [CHANNELS-1:0][FLIT_WIDTH-1:0] noc_in_flit_i,
   input  logic [CHANNELS-1:0]                 noc_in_last_i,
   input  logic [CHANNELS-1:0]                 noc_in_valid_i,
   output logic [CHANNELS-1:0]                 noc_in_ready_o,
   output logic [CHANNELS-1:0][FLIT_WIDTH-1:0] noc_out_flit_o,
   output logic [CHANNELS-1:0]                 noc_out_last_o,
   output logic [CHANNELS-1:0]                 noc_out_valid_o,
   input  logic [CHANNELS-1:0]                 noc_out_ready_i,
   output logic                                irq_o
);

   logic                                conf_stb;
   logic                                mp_stb;
   logic                                acc_we;
   logic [ADDR_OFS_W-1:0]               acc_ofs;
   logic [BUS_WIDTH-1:0]                acc_dat;
   logic [BUS_WIDTH-1:0]                conf_dat;
   logic [BUS_WIDTH-1:0]                mp_dat;
   logic                                mp_ready;
   logic                                irq_en;
   logic                                chan_sel;
   logic [CHANNELS-1:0]                 ch_stb;
   logic [CHANNELS-1:0][BUS_WIDTH-1:0]  ch_dat;
   logic [CHANNELS-1:0]                 ch_ready;
   logic [CHANNELS-1:0]                 ch_pending;

   // Between channel endpoints and NoC buffers
   logic [CHANNELS-1:0][FLIT_WIDTH-1:0] ib_flit;
   logic [CHANNELS-1:0]                 ib_last;
   logic [CHANNELS-1:0]                 ib_valid;
   logic [CHANNELS-1:0]                 ib_ready;
   logic [CHANNELS-1:0][FLIT_WIDTH-1:0] ob_flit;
   logic [CHANNELS-1:0]                 ob_last;
   logic [CHANNELS-1:0]                 ob_valid;
   logic [CHANNELS-1:0]                 ob_ready;

   na_wb_decode u_decode (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .wb_adr_i   (wb_adr_i),
      .wb_dat_i   (wb_dat_i),
      .wb_sel_i   (wb_sel_i),
      .wb_we_i    (wb_we_i),
      .wb_cyc_i   (wb_cyc_i),
      .wb_stb_i   (wb_stb_i),
      .wb_dat_o   (wb_dat_o),
      .wb_ack_o   (wb_ack_o),
      .wb_err_o   (wb_err_o),
      .conf_stb_o (conf_stb),
      .mp_stb_o   (mp_stb),
      .acc_we_o   (acc_we),
      .acc_ofs_o  (acc_ofs),
      .acc_dat_o  (acc_dat),
      .conf_dat_i (conf_dat),
      .mp_dat_i   (mp_dat),
      .mp_ready_i (mp_ready)
   );

   na_conf u_conf (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .stb_i    (conf_stb),
      .we_i     (acc_we),
      .ofs_i    (acc_ofs[REG_OFS_W-1:0]),
      .dat_i    (acc_dat),
      .dat_o    (conf_dat),
      .irq_en_o (irq_en)
   );

   // Address bit 8 picks the channel
   assign chan_sel = acc_ofs[CHAN_BIT];
   assign ch_stb   = mp_stb ? (CHANNELS'(1) << chan_sel) : '0;
   assign mp_dat   = ch_dat[chan_sel];
   assign mp_ready = ch_ready[chan_sel];

   assign irq_o = irq_en & (|ch_pending);

   for (genvar c = 0; c < CHANNELS; c++) begin : g_chan
      na_mp_channel u_mp (
         .clk            (clk),
         .rst_n_i        (rst_n_i),
         .stb_i          (ch_stb[c]),
         .we_i           (acc_we),
         .ofs_i          (acc_ofs[REG_OFS_W-1:0]),
         .dat_i          (acc_dat),
         .dat_o          (ch_dat[c]),
         .ready_o        (ch_ready[c]),
         .recv_pending_o (ch_pending[c]),
         .out_flit_o     (ob_flit[c]),
         .out_last_o     (ob_last[c]),
         .out_valid_o    (ob_valid[c]),
         .out_ready_i    (ob_ready[c]),
         .in_flit_i      (ib_flit[c]),
         .in_last_i      (ib_last[c]),
         .in_valid_i     (ib_valid[c]),
         .in_ready_o     (ib_ready[c])
      );

      na_flit_fifo #(.DEPTH(NOC_BUF_DEPTH)) u_outbuf (
         .clk         (clk),
         .rst_n_i     (rst_n_i),
         .in_flit_i   (ob_flit[c]),
         .in_last_i   (ob_last[c]),
         .in_valid_i  (ob_valid[c]),
         .in_ready_o  (ob_ready[c]),
         .out_flit_o  (noc_out_flit_o[c]),
         .out_last_o  (noc_out_last_o[c]),
         .out_valid_o (noc_out_valid_o[c]),
         .out_ready_i (noc_out_ready_i[c]),
         .count_o     ()
      );

      na_flit_fifo #(.DEPTH(NOC_BUF_DEPTH)) u_inbuf (
         .clk         (clk),
         .rst_n_i     (rst_n_i),
         .in_flit_i   (noc_in_flit_i[c]),
         .in_last_i   (noc_in_last_i[c]),
         .in_valid_i  (noc_in_valid_i[c]),
         .in_ready_o  (noc_in_ready_o[c]),
         .out_flit_o  (ib_flit[c]),
         .out_last_o  (ib_last[c]),
         .out_valid_o (ib_valid[c]),
         .out_ready_i (ib_ready[c]),
         .count_o     ()
      );
   end

endmodule

/* hdl/na_mp_channel.sv */
// Message-passing endpoint of one channel; receive read on empty queue returns stale data
module na_mp_channel
   import na_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n_i,
   input  logic                   stb_i,
   input  logic                   we_i,
   input  logic [REG_OFS_W-1:0]   ofs_i,
   input  logic [BUS_WIDTH-1:0]   dat_i,
   output logic [BUS_WIDTH-1:0]   dat_o,
   output logic                   ready_o,
   output logic                   recv_pending_o,
   output logic [FLIT_WIDTH-1:0]  out_flit_o,
   output logic                   out_last_o,
   output logic                   out_valid_o,
   input  logic                   out_ready_i,
   input  logic [FLIT_WIDTH-1:0]  in_flit_i,
   input  logic                   in_last_i,
   input  logic                   in_valid_i,
   output logic                   in_ready_o
);

   logic                            is_send;
   logic                            is_recv;
   logic                            send_valid;
   logic                            send_ready;
   logic [FLIT_WIDTH-1:0]           recv_flit;
   logic                            recv_last;
   logic                            recv_valid;
   logic                            recv_pop;
   logic [$clog2(RECV_DEPTH+1)-1:0] recv_count;
   logic                            rq_push;
   logic                            rq_ready;
   flit_t                           in_hdr;
   logic                            first_q;   // Next input flit is a header
   logic                            keep_q;
   logic                            keep_cur;
   logic [BUS_WIDTH-1:0]            status;

   assign is_send = (ofs_i == REG_SEND) | (ofs_i == REG_SEND_LAST);
   assign is_recv = (ofs_i == REG_RECV);

   // Send path
   assign send_valid = stb_i & we_i & is_send;
   assign ready_o    = ~(we_i & is_send & ~send_ready);

   na_flit_fifo #(
      .DEPTH (NOC_BUF_DEPTH)
   ) u_send_fifo (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .in_flit_i   (dat_i),
      .in_last_i   (ofs_i == REG_SEND_LAST),
      .in_valid_i  (send_valid),
      .in_ready_o  (send_ready),
      .out_flit_o  (out_flit_o),
      .out_last_o  (out_last_o),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i),
      .count_o     ()
   );

   // Receive filter, class of first flit decides the whole packet
   assign in_hdr.raw = in_flit_i;
   assign keep_cur   = first_q ? (in_hdr.hdr.cls == CLASS_MP) : keep_q;
   assign rq_push    = in_valid_i & keep_cur;
   assign in_ready_o = keep_cur ? rq_ready : 1'b1;   // Dropped flits just sink

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         first_q <= 1'b1;
         keep_q  <= 1'b0;
      end else if (in_valid_i && in_ready_o) begin
         first_q <= in_last_i;
         keep_q  <= keep_cur;
      end
   end

   assign recv_pop = stb_i & ~we_i & is_recv;

   na_flit_fifo #(
      .DEPTH (RECV_DEPTH)
   ) u_recv_fifo (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .in_flit_i   (in_flit_i),
      .in_last_i   (in_last_i),
      .in_valid_i  (rq_push),
      .in_ready_o  (rq_ready),
      .out_flit_o  (recv_flit),
      .out_last_o  (recv_last),
      .out_valid_o (recv_valid),
      .out_ready_i (recv_pop),
      .count_o     (recv_count)
   );

   assign recv_pending_o = (recv_count != '0);

   always_comb begin
      status                = '0;
      status[ST_RECV_NE]    = recv_pending_o;
      status[ST_RECV_LAST]  = recv_valid & recv_last;
      status[ST_SEND_SPACE] = send_ready;
   end

   always_comb begin
      case (ofs_i)
         REG_RECV:   dat_o = recv_flit;
         REG_STATUS: dat_o = status;
         default:    dat_o = '0;   // Send registers are write-only
      endcase
   end

endmodule

/* hdl/na_conf.sv */
// Configuration window; tile id and channel count are read-only, interrupt enable is bit 0
module na_conf
   import na_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  logic                  stb_i,
   input  logic                  we_i,
   input  logic [REG_OFS_W-1:0]  ofs_i,
   input  logic [BUS_WIDTH-1:0]  dat_i,
   output logic [BUS_WIDTH-1:0]  dat_o,
   output logic                  irq_en_o
);

   logic irq_en_q;

   assign irq_en_o = irq_en_q;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         irq_en_q <= 1'b0;
      end else if (stb_i && we_i && (ofs_i == REG_IRQ_EN)) begin
         irq_en_q <= dat_i[0];
      end
   end

   // Read mux, unknown offsets read zero
   always_comb begin
      dat_o = '0;
      case (ofs_i)
         REG_TILE_ID:  dat_o = BUS_WIDTH'(TILE_ID);
         REG_CHANNELS: dat_o = BUS_WIDTH'(CHANNELS);
         REG_IRQ_EN:   dat_o[0] = irq_en_q;
         default:      dat_o = '0;
      endcase
   end

endmodule

/* hdl/na_wb_decode.sv */
// Wishbone classic slave decode; single transfers only, writes need all byte selects set
module na_wb_decode
   import na_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n_i,
   input  logic [ADDR_WIDTH-1:0]  wb_adr_i,
   input  logic [BUS_WIDTH-1:0]   wb_dat_i,
   input  logic [SEL_WIDTH-1:0]   wb_sel_i,
   input  logic                   wb_we_i,
   input  logic                   wb_cyc_i,
   input  logic                   wb_stb_i,
   output logic [BUS_WIDTH-1:0]   wb_dat_o,
   output logic                   wb_ack_o,
   output logic                   wb_err_o,
   output logic                   conf_stb_o,
   output logic                   mp_stb_o,
   output logic                   acc_we_o,
   output logic [ADDR_OFS_W-1:0]  acc_ofs_o,
   output logic [BUS_WIDTH-1:0]   acc_dat_o,
   input  logic [BUS_WIDTH-1:0]   conf_dat_i,
   input  logic [BUS_WIDTH-1:0]   mp_dat_i,
   input  logic                   mp_ready_i
);

   logic [WIN_MSB-WIN_LSB:0] win;
   logic                     win_conf;
   logic                     win_mp;
   logic                     req;
   logic                     accept;
   logic                     ack_q;
   logic                     err_q;
   logic [BUS_WIDTH-1:0]     dat_q;

   assign win      = wb_adr_i[WIN_MSB:WIN_LSB];
   assign win_conf = (win == WIN_CONF);
   assign win_mp   = (win == WIN_MP);

   // Master still holds the request while ack/err is out
   assign req    = wb_cyc_i & wb_stb_i & ~ack_q & ~err_q;
   assign accept = req & (~win_mp | mp_ready_i);   // MP stalls on full send buffer

   assign conf_stb_o = accept & win_conf;
   assign mp_stb_o   = accept & win_mp;
   assign acc_we_o   = wb_we_i & (&wb_sel_i);
   assign acc_ofs_o  = wb_adr_i[ADDR_OFS_W-1:0];
   assign acc_dat_o  = wb_dat_i;

   assign wb_ack_o = ack_q;
   assign wb_err_o = err_q;
   assign wb_dat_o = dat_q;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= accept & (win_conf | win_mp);
         err_q <= accept & ~(win_conf | win_mp);   // Unmapped window
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         dat_q <= win_mp ? mp_dat_i : conf_dat_i;
      end
   end

endmodule

/* hdl/na_flit_fifo.sv */
// Flit FIFO with valid/ready on both sides; DEPTH must be 2 or more, full accepts push only with pop
module na_flit_fifo
   import na_pkg::*;
#(
   parameter int DEPTH = 4
) (
   input  logic                         clk,
   input  logic                         rst_n_i,
   input  logic [FLIT_WIDTH-1:0]        in_flit_i,
   input  logic                         in_last_i,
   input  logic                         in_valid_i,
   output logic                         in_ready_o,
   output logic [FLIT_WIDTH-1:0]        out_flit_o,
   output logic                         out_last_o,
   output logic                         out_valid_o,
   input  logic                         out_ready_i,
   output logic [$clog2(DEPTH+1)-1:0]   count_o
);

   logic [FLIT_WIDTH-1:0]        mem_flit [DEPTH];
   logic                         mem_last [DEPTH];
   logic [$clog2(DEPTH)-1:0]     wr_ptr;
   logic [$clog2(DEPTH)-1:0]     rd_ptr;
   logic [$clog2(DEPTH+1)-1:0]   count_q;
   logic                         push;
   logic                         pop;

   assign out_valid_o = (count_q != '0);
   assign in_ready_o  = (count_q != DEPTH) | out_ready_i;   // Full but draining
   assign push        = in_valid_i & in_ready_o;
   assign pop         = out_valid_o & out_ready_i;

   assign out_flit_o = mem_flit[rd_ptr];
   assign out_last_o = mem_last[rd_ptr];
   assign count_o    = count_q;

   always_ff @(posedge clk) begin
      if (push) begin
         mem_flit[wr_ptr] <= in_flit_i;
         mem_last[wr_ptr] <= in_last_i;
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count_q <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
         end
         // Occupancy
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

endmodule

/* hdl/na_pkg.sv */
// Shared constants and flit view of the adapter; bus is 32 bit, only address bits 23:0 decoded
package na_pkg;

   localparam int ADDR_WIDTH = 32;
   localparam int BUS_WIDTH  = 32;
   localparam int SEL_WIDTH  = 4;
   localparam int FLIT_WIDTH = 32;

   localparam int CHANNELS      = 2;    // 0 requests, 1 responses
   localparam int TILE_ID       = 5;
   localparam int NOC_BUF_DEPTH = 4;
   localparam int RECV_DEPTH    = 16;

   localparam logic [2:0] CLASS_MP = 3'd1;

   // Window select in address bits 23:20
   localparam int         WIN_MSB  = 23;
   localparam int         WIN_LSB  = 20;
   localparam logic [3:0] WIN_CONF = 4'h0;
   localparam logic [3:0] WIN_MP   = 4'h1;

   localparam int CHAN_BIT   = 8;              // Channel select inside MP window
   localparam int ADDR_OFS_W = CHAN_BIT + 1;   // Offset incl. channel bit
   localparam int REG_OFS_W  = 8;

   localparam logic [REG_OFS_W-1:0] REG_TILE_ID  = 8'h0;
   localparam logic [REG_OFS_W-1:0] REG_CHANNELS = 8'h4;
   localparam logic [REG_OFS_W-1:0] REG_IRQ_EN   = 8'h8;

   localparam logic [REG_OFS_W-1:0] REG_SEND      = 8'h0;
   localparam logic [REG_OFS_W-1:0] REG_SEND_LAST = 8'h4;
   localparam logic [REG_OFS_W-1:0] REG_RECV      = 8'h8;
   localparam logic [REG_OFS_W-1:0] REG_STATUS    = 8'hC;

   // Status word bits
   localparam int ST_RECV_NE    = 0;
   localparam int ST_RECV_LAST  = 1;
   localparam int ST_SEND_SPACE = 2;

   // Header flit vs. plain data word
   typedef union packed {
      struct packed {
         logic [4:0]  dest;
         logic [2:0]  cls;
         logic [4:0]  src;
         logic [18:0] payload;
      } hdr;
      logic [FLIT_WIDTH-1:0] raw;
   } flit_t;

endpackage
